//--- design/dll_rx_pkg.sv
package dll_rx_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int PIPE_DATA_W = 256;                   // one pipe beat
    localparam int CREDIT_W    = 12;
    localparam int SEQ_W       = 12;
    localparam int TL_HDR_W    = 128;                   // np header to the TL

    // ------------------------------------------------------------------------
    // protocol constants
    // ------------------------------------------------------------------------
    localparam logic [15:0] DLLP_MARKER = 16'hACF0;     // bits 15:0 of a dllp beat
    localparam logic [15:0] CRC16_POLY  = 16'h100B;
    localparam logic [15:0] CRC16_INIT  = 16'hFFFF;
    localparam logic [3:0]  NP_TLP_TAG  = 4'hF;         // low nibble of an np tlp

    typedef enum logic [7:0] {
        DLLP_ACK       = 8'h00,
        DLLP_NAK       = 8'h10,
        DLLP_INIT1_P   = 8'h40,
        DLLP_INIT1_NP  = 8'h50,
        DLLP_INIT1_CPL = 8'h60,
        DLLP_FC_P      = 8'h80,
        DLLP_FC_NP     = 8'h90,
        DLLP_FC_CPL    = 8'hA0,
        DLLP_INIT2_P   = 8'hC0,
        DLLP_INIT2_NP  = 8'hD0,
        DLLP_INIT2_CPL = 8'hE0
    } dllp_type_e;

    typedef enum logic [1:0] {
        ACKNAK_NONE = 2'd0,
        ACKNAK_ACK  = 2'd1,
        ACKNAK_NAK  = 2'd2
    } acknak_kind_e;

    typedef enum logic [2:0] {
        TL_NONE   = 3'd0,
        TL_NP_HDR = 3'd3,
        TL_DONE   = 3'd7
    } tl_strobe_e;

    typedef enum logic [1:0] {DLLP_IDLE, DLLP_CRC_CHECK, DLLP_GET_DATA} dllp_state_e;

    typedef enum logic [1:0] {TLP_IDLE, TLP_SEQ_CHECK, TLP_SEND, TLP_DONE} tlp_state_e;

    // ------------------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [CREDIT_W-1:0] hdr_credit;
        logic [CREDIT_W-1:0] data_credit;
    } fc_credit_t;

    typedef struct packed {
        logic       valid;                              // one-cycle pulse
        fc_credit_t credit;
    } fc_update_t;

    typedef struct packed {
        logic                valid;
        logic [CREDIT_W-1:0] hdr_credit;                // np has no data credit here
    } np_update_t;

    typedef struct packed {
        acknak_kind_e     kind;
        logic [SEQ_W-1:0] seq_num;
    } acknak_t;

    typedef struct packed {
        tl_strobe_e          strobe;
        logic [TL_HDR_W-1:0] hdr;
    } tl_out_t;

endpackage

//--- design/dll_rx_top.sv
`timescale 1ns/1ps

module dll_rx_top (
    input  logic                               sclk,
    input  logic                               srst_n,
    input  logic                               pipe_valid_i,
    input  logic [dll_rx_pkg::PIPE_DATA_W-1:0] pipe_data_i,

    // ------------------------------------------------------------------------
    // flow control and ack/nak, from dllps
    // ------------------------------------------------------------------------
    output dll_rx_pkg::fc_credit_t             fc_limit_p_o,
    output dll_rx_pkg::fc_credit_t             fc_limit_cpl_o,
    output logic [dll_rx_pkg::CREDIT_W-1:0]    fc_limit_np_hdr_o,
    output logic                               init1_received_o,
    output logic                               init2_received_o,
    output dll_rx_pkg::fc_update_t             fc_update_p_o,
    output dll_rx_pkg::fc_update_t             fc_update_cpl_o,
    output dll_rx_pkg::np_update_t             fc_update_np_o,
    output dll_rx_pkg::acknak_t                acknak_o,

    // ------------------------------------------------------------------------
    // np tlp path
    // ------------------------------------------------------------------------
    output logic [dll_rx_pkg::SEQ_W-1:0]       next_rcv_seq_o,
    output logic                               nak_scheduled_o,
    output dll_rx_pkg::tl_out_t                tl_out_o
);

    logic tlp_beat_valid;                               // non-dllp beat this cycle

    dllp_decoder dllp_decoder_inst (
        .sclk              (sclk),
        .srst_n            (srst_n),
        .pipe_valid_i      (pipe_valid_i),
        .pipe_data_i       (pipe_data_i),
        .tlp_beat_valid_o  (tlp_beat_valid),
        .fc_limit_p_o      (fc_limit_p_o),
        .fc_limit_cpl_o    (fc_limit_cpl_o),
        .fc_limit_np_hdr_o (fc_limit_np_hdr_o),
        .init1_received_o  (init1_received_o),
        .init2_received_o  (init2_received_o),
        .fc_update_p_o     (fc_update_p_o),
        .fc_update_cpl_o   (fc_update_cpl_o),
        .fc_update_np_o    (fc_update_np_o),
        .acknak_o          (acknak_o)
    );

    tlp_seq_checker tlp_seq_checker_inst (
        .sclk             (sclk),
        .srst_n           (srst_n),
        .tlp_beat_valid_i (tlp_beat_valid),
        .pipe_data_i      (pipe_data_i),             // same beat, shared
        .next_rcv_seq_o   (next_rcv_seq_o),
        .nak_scheduled_o  (nak_scheduled_o),
        .tl_out_o         (tl_out_o)
    );

endmodule

//--- design/dllp_crc16.sv
`timescale 1ns/1ps

// CRC-16 over the 32-bit DLLP body, bit serial form unrolled into logic.
// Body bit 31 enters first.
module dllp_crc16 (
    input  logic [31:0] body_i,
    output logic [15:0] crc_o
);

    // ------------------------------------------------------------------------
    // 32 shift steps, msb first
    // ------------------------------------------------------------------------
    always_comb begin
        crc_o = dll_rx_pkg::CRC16_INIT;
        for (int i = 31; i >= 0; i--) begin
            if (crc_o[15] ^ body_i[i]) begin
                crc_o = {crc_o[14:0], 1'b0} ^ dll_rx_pkg::CRC16_POLY;  // feedback tap
            end
            else begin
                crc_o = {crc_o[14:0], 1'b0};
            end
        end
    end

    // the receiver compares the inverted result against bits 63:48,
    // so nothing is inverted here and a transmitter can reuse the block

endmodule

//--- design/dllp_decoder.sv
`timescale 1ns/1ps

module dllp_decoder (
    input  logic                               sclk,
    input  logic                               srst_n,
    input  logic                               pipe_valid_i,
    input  logic [dll_rx_pkg::PIPE_DATA_W-1:0] pipe_data_i,
    output logic                               tlp_beat_valid_o,
    output dll_rx_pkg::fc_credit_t             fc_limit_p_o,
    output dll_rx_pkg::fc_credit_t             fc_limit_cpl_o,
    output logic [dll_rx_pkg::CREDIT_W-1:0]    fc_limit_np_hdr_o,
    output logic                               init1_received_o,
    output logic                               init2_received_o,
    output dll_rx_pkg::fc_update_t             fc_update_p_o,
    output dll_rx_pkg::fc_update_t             fc_update_cpl_o,
    output dll_rx_pkg::np_update_t             fc_update_np_o,
    output dll_rx_pkg::acknak_t                acknak_o
);

    dll_rx_pkg::dllp_state_e             state_q;
    dll_rx_pkg::dllp_state_e             state_d;
    dll_rx_pkg::dllp_type_e              opcode;
    logic [63:16]                        dllp_q;        // captured dllp, marker dropped
    logic                                is_dllp;
    logic [15:0]                         crc;
    logic                                crc_ok;
    logic [dll_rx_pkg::CREDIT_W-1:0]     hdr_field;
    logic [dll_rx_pkg::CREDIT_W-1:0]     data_field;    // also ack/nak seq number
    logic                                init2_p_q;
    logic                                init2_np_q;
    logic                                init2_cpl_q;

    // ------------------------------------------------------------------------
    // beat routing
    // ------------------------------------------------------------------------
    assign is_dllp          = pipe_valid_i && (pipe_data_i[15:0] == dll_rx_pkg::DLLP_MARKER);
    assign tlp_beat_valid_o = pipe_valid_i && !is_dllp;        // everything else is a tlp

    always_ff @(posedge sclk) begin
        if (state_q == dll_rx_pkg::DLLP_IDLE && is_dllp) begin
            dllp_q <= pipe_data_i[63:16];
        end
    end

    dllp_crc16 dllp_crc16_inst (
        .body_i (dllp_q[47:16]),
        .crc_o  (crc)
    );

    assign crc_ok = (dllp_q[63:48] == ~crc);

    // field extraction
    assign opcode     = dll_rx_pkg::dllp_type_e'(dllp_q[23:16]);
    assign hdr_field  = {{(dll_rx_pkg::CREDIT_W-8){1'b0}}, dllp_q[29:24], dllp_q[39:38]};
    assign data_field = {dllp_q[35:32], dllp_q[47:40]};

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            dll_rx_pkg::DLLP_IDLE: begin
                if (is_dllp) begin
                    state_d = dll_rx_pkg::DLLP_CRC_CHECK;
                end
            end
            dll_rx_pkg::DLLP_CRC_CHECK: begin
                state_d = crc_ok ? dll_rx_pkg::DLLP_GET_DATA : dll_rx_pkg::DLLP_IDLE;
            end
            default: begin
                state_d = dll_rx_pkg::DLLP_IDLE;                // get_data lasts one cycle
            end
        endcase
    end

    always_ff @(posedge sclk) begin
        if (!srst_n) begin
            state_q           <= dll_rx_pkg::DLLP_IDLE;
            fc_limit_p_o      <= '0;
            fc_limit_cpl_o    <= '0;
            fc_limit_np_hdr_o <= '0;
            init2_p_q         <= 1'b0;
            init2_np_q        <= 1'b0;
            init2_cpl_q       <= 1'b0;
            fc_update_p_o     <= '0;
            fc_update_cpl_o   <= '0;
            fc_update_np_o    <= '0;
            acknak_o          <= '0;
        end
        else begin
            state_q               <= state_d;
            fc_update_p_o.valid   <= 1'b0;                      // pulses last one cycle
            fc_update_cpl_o.valid <= 1'b0;
            fc_update_np_o.valid  <= 1'b0;
            acknak_o.kind         <= dll_rx_pkg::ACKNAK_NONE;
            if (state_q == dll_rx_pkg::DLLP_GET_DATA) begin
                case (opcode)
                    dll_rx_pkg::DLLP_INIT1_P: begin
                        fc_limit_p_o <= '{hdr_credit: hdr_field, data_credit: data_field};
                    end
                    dll_rx_pkg::DLLP_INIT1_NP: begin
                        fc_limit_np_hdr_o <= hdr_field;
                    end
                    dll_rx_pkg::DLLP_INIT1_CPL: begin
                        fc_limit_cpl_o <= '{hdr_credit: hdr_field, data_credit: data_field};
                    end
                    dll_rx_pkg::DLLP_INIT2_P:   init2_p_q   <= 1'b1;
                    dll_rx_pkg::DLLP_INIT2_NP:  init2_np_q  <= 1'b1;
                    dll_rx_pkg::DLLP_INIT2_CPL: init2_cpl_q <= 1'b1;
                    dll_rx_pkg::DLLP_FC_P: begin
                        fc_update_p_o <= '{valid: 1'b1,
                                           credit: '{hdr_credit: hdr_field,
                                                     data_credit: data_field}};
                    end
                    dll_rx_pkg::DLLP_FC_NP: begin
                        fc_update_np_o <= '{valid: 1'b1, hdr_credit: hdr_field};
                    end
                    dll_rx_pkg::DLLP_FC_CPL: begin
                        fc_update_cpl_o <= '{valid: 1'b1,
                                             credit: '{hdr_credit: hdr_field,
                                                       data_credit: data_field}};
                    end
                    dll_rx_pkg::DLLP_ACK: begin
                        acknak_o <= '{kind: dll_rx_pkg::ACKNAK_ACK, seq_num: data_field};
                    end
                    dll_rx_pkg::DLLP_NAK: begin
                        acknak_o <= '{kind: dll_rx_pkg::ACKNAK_NAK, seq_num: data_field};
                    end
                    default: ;                                  // unknown opcode, dropped
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    // init status
    // ------------------------------------------------------------------------
    assign init1_received_o = (|fc_limit_p_o.hdr_credit) && (|fc_limit_p_o.data_credit) &&
                              (|fc_limit_np_hdr_o) &&
                              (|fc_limit_cpl_o.hdr_credit) && (|fc_limit_cpl_o.data_credit);
    assign init2_received_o = init2_p_q && init2_np_q && init2_cpl_q;  // flags are sticky

endmodule

//--- design/tlp_seq_checker.sv
`timescale 1ns/1ps

module tlp_seq_checker (
    input  logic                               sclk,
    input  logic                               srst_n,
    input  logic                               tlp_beat_valid_i,
    input  logic [dll_rx_pkg::PIPE_DATA_W-1:0] pipe_data_i,
    output logic [dll_rx_pkg::SEQ_W-1:0]       next_rcv_seq_o,
    output logic                               nak_scheduled_o,
    output dll_rx_pkg::tl_out_t                tl_out_o
);

    dll_rx_pkg::tlp_state_e            state_q;
    dll_rx_pkg::tlp_state_e            state_d;
    dll_rx_pkg::tl_strobe_e            strobe_q;
    logic                              is_np;
    logic [dll_rx_pkg::SEQ_W-1:0]      tlp_seq_q;       // seq of the captured tlp
    logic [dll_rx_pkg::TL_HDR_W-1:0]   tlp_hdr_q;
    logic [dll_rx_pkg::TL_HDR_W-1:0]   hdr_q;           // header as presented to the TL
    logic                              seq_match;

    assign is_np     = tlp_beat_valid_i && (pipe_data_i[3:0] == dll_rx_pkg::NP_TLP_TAG);
    assign seq_match = (tlp_seq_q == next_rcv_seq_o);

    // ------------------------------------------------------------------------
    // capture and header registers
    // ------------------------------------------------------------------------
    always_ff @(posedge sclk) begin
        if (state_q == dll_rx_pkg::TLP_IDLE && is_np) begin
            tlp_seq_q <= {pipe_data_i[19:16], pipe_data_i[31:24]};
            tlp_hdr_q <= pipe_data_i[159:32];
        end
        if (state_q == dll_rx_pkg::TLP_SEND) begin
            hdr_q <= tlp_hdr_q;                             // held through done
        end
    end

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            dll_rx_pkg::TLP_IDLE: begin
                if (is_np) begin
                    state_d = dll_rx_pkg::TLP_SEQ_CHECK;    // beats while busy are dropped
                end
            end
            dll_rx_pkg::TLP_SEQ_CHECK: begin
                state_d = seq_match ? dll_rx_pkg::TLP_SEND : dll_rx_pkg::TLP_IDLE;
            end
            dll_rx_pkg::TLP_SEND: state_d = dll_rx_pkg::TLP_DONE;
            default:              state_d = dll_rx_pkg::TLP_IDLE;
        endcase
    end

    always_ff @(posedge sclk) begin
        if (!srst_n) begin
            state_q         <= dll_rx_pkg::TLP_IDLE;
            strobe_q        <= dll_rx_pkg::TL_NONE;
            next_rcv_seq_o  <= '0;
            nak_scheduled_o <= 1'b0;
        end
        else begin
            state_q <= state_d;
            case (state_q)
                dll_rx_pkg::TLP_SEQ_CHECK: begin
                    if (seq_match) begin
                        next_rcv_seq_o  <= next_rcv_seq_o + 1'b1;   // wraps at 12 bits
                        nak_scheduled_o <= 1'b0;
                    end
                    else begin
                        nak_scheduled_o <= 1'b1;                    // sticky until a good tlp
                    end
                end
                dll_rx_pkg::TLP_SEND: strobe_q <= dll_rx_pkg::TL_NP_HDR;
                dll_rx_pkg::TLP_DONE: strobe_q <= dll_rx_pkg::TL_DONE;
                default:              strobe_q <= dll_rx_pkg::TL_NONE;
            endcase
        end
    end

    assign tl_out_o = '{strobe: strobe_q, hdr: hdr_q};

endmodule

//--- dv/dll_rx_tb.sv
`timescale 1ns/1ps

module dll_rx_tb;

    logic                               sclk;
    logic                               srst_n;
    logic                               pipe_valid_i;
    logic [dll_rx_pkg::PIPE_DATA_W-1:0] pipe_data_i;
    dll_rx_pkg::fc_credit_t             fc_limit_p_o;
    dll_rx_pkg::fc_credit_t             fc_limit_cpl_o;
    logic [dll_rx_pkg::CREDIT_W-1:0]    fc_limit_np_hdr_o;
    logic                               init1_received_o;
    logic                               init2_received_o;
    dll_rx_pkg::fc_update_t             fc_update_p_o;
    dll_rx_pkg::fc_update_t             fc_update_cpl_o;
    dll_rx_pkg::np_update_t             fc_update_np_o;
    dll_rx_pkg::acknak_t                acknak_o;
    logic [dll_rx_pkg::SEQ_W-1:0]       next_rcv_seq_o;
    logic                               nak_scheduled_o;
    dll_rx_pkg::tl_out_t                tl_out_o;

    // expected state, moved at the rising edge where the DUT changes
    dll_rx_pkg::fc_credit_t          exp_lim_p;
    dll_rx_pkg::fc_credit_t          exp_lim_cpl;
    logic [dll_rx_pkg::CREDIT_W-1:0] exp_lim_np;
    logic [2:0]                      exp_init2;             // cpl, np, p seen
    dll_rx_pkg::fc_update_t          exp_upd_p;
    dll_rx_pkg::fc_update_t          exp_upd_cpl;
    dll_rx_pkg::np_update_t          exp_upd_np;
    dll_rx_pkg::acknak_t             exp_acknak;
    logic [dll_rx_pkg::SEQ_W-1:0]    exp_next_seq;
    logic                            exp_nak;
    logic                            checking;
    logic [31:0]                     lfsr;
    int                              errors;
    int                              test_err;
    int                              tests;
    int                              failed;
    string                           test_name;

    dll_rx_top dll_rx_top_inst (.*);

    always #10 sclk = ~sclk;

    // ------------------------------------------------------------------------
    // random source and reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};      // taps 32 22 2 1
    endfunction

    task automatic rand_bits(input int n, input bit nonzero, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};                      // one step per bit
        end
        if (nonzero && v == '0) begin
            v = 32'd1;
        end
    endtask

    function automatic logic [15:0] crc_ref(input logic [31:0] body);
        logic [15:0] c;
        logic        msb;
        c = dll_rx_pkg::CRC16_INIT;
        for (int i = 31; i >= 0; i--) begin
            msb = c[15];
            c   = {c[14:0], 1'b0};
            if (msb != body[i]) begin
                c = c ^ dll_rx_pkg::CRC16_POLY;
            end
        end
        return c;
    endfunction

    function automatic logic init1_ref();
        return (exp_lim_p.hdr_credit != 0) && (exp_lim_p.data_credit != 0) &&
               (exp_lim_np != 0) &&
               (exp_lim_cpl.hdr_credit != 0) && (exp_lim_cpl.data_credit != 0);
    endfunction

    function automatic logic [255:0] make_dllp(input logic [7:0] op, input logic [7:0] hdr,
                                               input logic [11:0] data);
        logic [255:0] b;
        b        = '0;
        b[15:0]  = dll_rx_pkg::DLLP_MARKER;
        b[23:16] = op;
        b[29:24] = hdr[7:2];
        b[39:38] = hdr[1:0];
        b[35:32] = data[11:8];
        b[47:40] = data[7:0];
        b[63:48] = ~crc_ref(b[47:16]);
        return b;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        errors++;
        test_err++;
    endtask

    task automatic check_val(input string name, input logic [130:0] got,
                             input logic [130:0] exp);
        if (got !== exp) begin
            report_error($sformatf("MISMATCH %s: got %0h, expected %0h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // compare process, outputs sampled mid cycle
    // ------------------------------------------------------------------------
    always @(negedge sclk) begin
        if (checking) begin
            check_val("fc_limit_p_o", fc_limit_p_o, exp_lim_p);
            check_val("fc_limit_cpl_o", fc_limit_cpl_o, exp_lim_cpl);
            check_val("fc_limit_np_hdr_o", fc_limit_np_hdr_o, exp_lim_np);
            check_val("init1_received_o", init1_received_o, init1_ref());
            check_val("init2_received_o", init2_received_o, &exp_init2);
            check_val("fc_update_p_o", fc_update_p_o, exp_upd_p);
            check_val("fc_update_cpl_o", fc_update_cpl_o, exp_upd_cpl);
            check_val("fc_update_np_o", fc_update_np_o, exp_upd_np);
            check_val("acknak_o", acknak_o, exp_acknak);
            check_val("next_rcv_seq_o", next_rcv_seq_o, exp_next_seq);
            check_val("nak_scheduled_o", nak_scheduled_o, exp_nak);
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic apply_dllp(input logic [7:0] op, input logic [7:0] hdr,
                              input logic [11:0] data);
        logic [11:0] h;
        h = {4'h0, hdr};
        case (op)
            dll_rx_pkg::DLLP_INIT1_P:   exp_lim_p   = '{hdr_credit: h, data_credit: data};
            dll_rx_pkg::DLLP_INIT1_NP:  exp_lim_np  = h;
            dll_rx_pkg::DLLP_INIT1_CPL: exp_lim_cpl = '{hdr_credit: h, data_credit: data};
            dll_rx_pkg::DLLP_INIT2_P:   exp_init2[0] = 1'b1;
            dll_rx_pkg::DLLP_INIT2_NP:  exp_init2[1] = 1'b1;
            dll_rx_pkg::DLLP_INIT2_CPL: exp_init2[2] = 1'b1;
            dll_rx_pkg::DLLP_FC_P:      exp_upd_p   = {1'b1, h, data};
            dll_rx_pkg::DLLP_FC_NP:     exp_upd_np  = {1'b1, h};
            dll_rx_pkg::DLLP_FC_CPL:    exp_upd_cpl = {1'b1, h, data};
            dll_rx_pkg::DLLP_ACK:       exp_acknak  = '{kind: dll_rx_pkg::ACKNAK_ACK, seq_num: data};
            dll_rx_pkg::DLLP_NAK:       exp_acknak  = '{kind: dll_rx_pkg::ACKNAK_NAK, seq_num: data};
            default: ;
        endcase
    endtask

    task automatic send_dllp(input logic [7:0] op, input logic [7:0] hdr,
                             input logic [11:0] data, input bit corrupt);
        pipe_valid_i = 1'b1;
        pipe_data_i  = make_dllp(op, hdr, data);
        if (corrupt) begin
            pipe_data_i[48] = ~pipe_data_i[48];            // one bad crc bit
        end
        @(posedge sclk);                                    // edge k
        @(negedge sclk);
        pipe_valid_i = 1'b0;
        @(posedge sclk);
        @(posedge sclk);                                    // edge k+2, decode lands
        if (!corrupt) begin
            apply_dllp(op, hdr, data);
        end
        @(posedge sclk);                                    // pulses drop
        exp_upd_p.valid   = 1'b0;
        exp_upd_cpl.valid = 1'b0;
        exp_upd_np.valid  = 1'b0;
        exp_acknak.kind   = dll_rx_pkg::ACKNAK_NONE;
        @(negedge sclk);
    endtask

    task automatic send_tlp(input logic [11:0] seq, input logic [127:0] hdr);
        logic match;
        int   cycles;
        match                = (seq == exp_next_seq);
        pipe_valid_i         = 1'b1;
        pipe_data_i          = '0;
        pipe_data_i[3:0]     = dll_rx_pkg::NP_TLP_TAG;
        pipe_data_i[19:16]   = seq[11:8];
        pipe_data_i[31:24]   = seq[7:0];
        pipe_data_i[159:32]  = hdr;
        @(posedge sclk);                                    // edge k
        @(negedge sclk);
        pipe_valid_i = 1'b0;
        @(posedge sclk);                                    // sequence verdict
        exp_nak = !match;
        if (match) begin
            exp_next_seq = exp_next_seq + 1'b1;
        end
        cycles = 1;
        @(negedge sclk);
        while (tl_out_o.strobe == dll_rx_pkg::TL_NONE && cycles < 6) begin
            @(negedge sclk);
            cycles++;
        end
        if (!match) begin
            check_val("tl_out_o.strobe", tl_out_o.strobe, dll_rx_pkg::TL_NONE);
        end
        else if (tl_out_o.strobe == dll_rx_pkg::TL_NONE) begin
            report_error("ERROR: no header strobe within 6 cycles of the TLP beat");
        end
        else begin
            check_val("header latency", cycles, 2);
            check_val("tl_out_o.strobe", tl_out_o.strobe, dll_rx_pkg::TL_NP_HDR);
            check_val("tl_out_o.hdr", tl_out_o.hdr, hdr);
            @(negedge sclk);
            check_val("tl_out_o.strobe", tl_out_o.strobe, dll_rx_pkg::TL_DONE);
            check_val("tl_out_o.hdr", tl_out_o.hdr, hdr);
            @(negedge sclk);
            check_val("tl_out_o.strobe", tl_out_o.strobe, dll_rx_pkg::TL_NONE);
        end
    endtask

    task automatic rand_hdr(output logic [127:0] hdr);
        logic [31:0] w;
        hdr = '0;
        for (int i = 0; i < 4; i++) begin
            rand_bits(32, 1'b0, w);
            hdr = {hdr[95:0], w};
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = 0;
        tests++;
    endtask

    task automatic end_test();
        if (test_err != 0) begin
            failed++;
        end
        $display("%s: %s, %0d errors", test_name, (test_err == 0) ? "ok" : "failed", test_err);
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0]  h;
        logic [31:0]  d;
        logic [127:0] hdr;
        logic [7:0]   ops [3];
        sclk = 1'b0;
        srst_n = 1'b0;
        pipe_valid_i = 1'b0;
        pipe_data_i = '0;
        exp_lim_p = '0;
        exp_lim_cpl = '0;
        exp_lim_np = '0;
        exp_init2 = '0;
        exp_upd_p = '0;
        exp_upd_cpl = '0;
        exp_upd_np = '0;
        exp_acknak = '0;
        exp_next_seq = '0;
        exp_nak = 1'b0;
        checking = 1'b0;
        lfsr = 32'hbe45_6790;
        errors = 0;
        tests = 0;
        failed = 0;
        repeat (2) @(posedge sclk);
        @(negedge sclk);
        srst_n = 1'b1;
        @(posedge sclk);
        checking = 1'b1;
        @(negedge sclk);

        start_test("reset state");
        repeat (3) begin
            check_val("tl_out_o.strobe", tl_out_o.strobe, dll_rx_pkg::TL_NONE);
            @(negedge sclk);
        end
        end_test();

        start_test("init flow control");
        ops = '{dll_rx_pkg::DLLP_INIT1_P, dll_rx_pkg::DLLP_INIT1_NP, dll_rx_pkg::DLLP_INIT1_CPL};
        foreach (ops[i]) begin
            rand_bits(8, 1'b1, h);
            rand_bits(12, 1'b1, d);
            send_dllp(ops[i], h[7:0], d[11:0], 1'b0);       // init1 rises after the last
        end
        ops = '{dll_rx_pkg::DLLP_INIT2_P, dll_rx_pkg::DLLP_INIT2_NP, dll_rx_pkg::DLLP_INIT2_CPL};
        foreach (ops[i]) begin
            rand_bits(8, 1'b0, h);
            send_dllp(ops[i], h[7:0], 12'h000, 1'b0);
        end
        end_test();

        start_test("update flow control");
        ops = '{dll_rx_pkg::DLLP_FC_P, dll_rx_pkg::DLLP_FC_NP, dll_rx_pkg::DLLP_FC_CPL};
        foreach (ops[i]) begin
            rand_bits(8, 1'b0, h);
            rand_bits(12, 1'b0, d);
            send_dllp(ops[i], h[7:0], d[11:0], 1'b0);
        end
        send_dllp(dll_rx_pkg::DLLP_FC_P, 8'h5a, 12'h3c3, 1'b1);
        send_dllp(dll_rx_pkg::DLLP_INIT1_NP, 8'h00, 12'h000, 1'b1);  // would clear init1
        end_test();

        start_test("ack and nak");
        rand_bits(12, 1'b0, d);
        send_dllp(dll_rx_pkg::DLLP_ACK, 8'h00, d[11:0], 1'b0);
        rand_bits(12, 1'b0, d);
        send_dllp(dll_rx_pkg::DLLP_NAK, 8'h00, d[11:0], 1'b0);
        repeat (2) @(negedge sclk);                         // seq num holds
        end_test();

        start_test("np tlp sequence");
        rand_hdr(hdr);
        send_tlp(exp_next_seq, hdr);
        rand_hdr(hdr);
        send_tlp(exp_next_seq + 12'd5, hdr);                // out of order, nak
        rand_hdr(hdr);
        send_tlp(exp_next_seq, hdr);
        end_test();

        @(posedge sclk);
        checking = 1'b0;
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end
        else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
design/dll_rx_pkg.sv
design/dllp_crc16.sv
design/dllp_decoder.sv
design/tlp_seq_checker.sv
design/dll_rx_top.sv
dv/dll_rx_tb.sv
